/* hw/cmd_pkg.sv */
/*
 Command word layout and the encodings used by the decoder.
 Opcode sits in the top nibble and the byte count in the lower 28 bits.
 Only NOP, STORE, MEMSET and STREAM are decoded. Other opcodes are not
 supported and the byte count must be a non-zero multiple of 4.
*/
package cmd_pkg;

    // Opcode field
    localparam int op_pos = 28;
    localparam int op_size = 4;

    // Immediate field, a byte count
    localparam int imm_pos = 0;
    localparam int imm_size = 28;

    typedef enum logic [op_size-1:0]
    {
        op_nop    = 4'd0,
        op_store  = 4'd5,
        op_memset = 4'd7,
        op_stream = 4'd8
    } opcode_t;

    // Parsing states first, BUSY waits for the job to drain
    typedef enum logic [2:0]
    {
        st_idle,
        st_command,
        st_store_addr,
        st_memset_addr,
        st_memset_val,
        st_busy
    } decoder_state_t;

endpackage

/* hw/bus_pkg.sv */
/*
 Bus widths and the structs shared by the datapath.
 Field layout assumes a 32-bit word, so the widths are fixed.
 Memory addresses are byte addresses, one word per beat.
*/
package bus_pkg;

    localparam int data_width = 32;
    localparam int addr_width = 16;
    localparam int bytes_per_beat = data_width / 8;
    localparam int beat_shift = 2;

    typedef logic [data_width-1:0] data_t;
    typedef logic [addr_width-1:0] addr_t;

    // A byte count turned into words loses the two low bits
    typedef logic [cmd_pkg::imm_size-beat_shift-1:0] beat_count_t;

    typedef struct packed
    {
        data_t data;
        logic  last;
    } beat_t;

    typedef struct packed
    {
        cmd_pkg::opcode_t op;
        beat_count_t      beats;
        data_t            fill;
    } job_t;

endpackage

/* hw/cmd_decoder.sv */
`timescale 1ns/1ps
/*
 Parses the command stream and launches one job at a time.
 Takes the command word, then the address word (STORE, MEMSET) and the
 value word (MEMSET). Waits until both the mover and the address
 generator are done before the next command is parsed.
*/
module cmd_decoder
(
    input  logic                 aclk,
    input  logic                 resetn,
    input  logic                 s_cmd_valid,
    input  bus_pkg::beat_t       s_cmd_beat,
    output logic                 parse_ready,
    output bus_pkg::job_t        job,
    output logic                 mover_start,
    input  logic                 mover_done,
    output bus_pkg::addr_t       aw_base,
    output bus_pkg::beat_count_t aw_beats,
    output logic                 aw_start,
    input  logic                 aw_idle
);
    cmd_pkg::decoder_state_t state;
    cmd_pkg::opcode_t        cmd_op;
    logic [cmd_pkg::imm_size-1:0] cmd_bytes;
    bus_pkg::beat_count_t    cmd_beats;
    logic                    word_taken;
    logic                    done_seen;

    // Split the command word
    assign cmd_op = cmd_pkg::opcode_t'(s_cmd_beat.data[cmd_pkg::op_pos +: cmd_pkg::op_size]);
    assign cmd_bytes = s_cmd_beat.data[cmd_pkg::imm_pos +: cmd_pkg::imm_size];
    assign cmd_beats = bus_pkg::beat_count_t'(cmd_bytes >> bus_pkg::beat_shift);

    // Ready in every state that consumes a word
    always_comb
    begin
        case (state)
            cmd_pkg::st_command,
            cmd_pkg::st_store_addr,
            cmd_pkg::st_memset_addr,
            cmd_pkg::st_memset_val: parse_ready = 1'b1;
            default: parse_ready = 1'b0;
        endcase
    end

    assign word_taken = s_cmd_valid && parse_ready;
    assign aw_beats = job.beats;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= cmd_pkg::st_idle;
            mover_start <= 1'b0;
            aw_start <= 1'b0;
            done_seen <= 1'b0;
        end
        else
        begin
            mover_start <= 1'b0;
            aw_start <= 1'b0;
            case (state)
                cmd_pkg::st_idle:
                begin
                    done_seen <= 1'b0;
                    state <= cmd_pkg::st_command;
                end
                cmd_pkg::st_command:
                begin
                    if (word_taken)
                    begin
                        case (cmd_op)
                            cmd_pkg::op_stream:
                            begin
                                mover_start <= 1'b1;
                                state <= cmd_pkg::st_busy;
                            end
                            cmd_pkg::op_store: state <= cmd_pkg::st_store_addr;
                            cmd_pkg::op_memset: state <= cmd_pkg::st_memset_addr;
                            // NOP, and anything unknown, is dropped
                            default: state <= cmd_pkg::st_idle;
                        endcase
                    end
                end
                cmd_pkg::st_store_addr,
                cmd_pkg::st_memset_val:
                begin
                    if (word_taken)
                    begin
                        mover_start <= 1'b1;
                        aw_start <= 1'b1;
                        state <= cmd_pkg::st_busy;
                    end
                end
                cmd_pkg::st_memset_addr:
                begin
                    if (word_taken)
                    begin
                        state <= cmd_pkg::st_memset_val;
                    end
                end
                cmd_pkg::st_busy:
                begin
                    if (mover_done)
                    begin
                        done_seen <= 1'b1;
                    end
                    // Address side may finish before or after the data side
                    if ((done_seen || mover_done) && aw_idle)
                    begin
                        state <= cmd_pkg::st_idle;
                    end
                end
                default: state <= cmd_pkg::st_idle;
            endcase
        end
    end

    // Job fields, captured as their words arrive
    always_ff @(posedge aclk)
    begin
        if (word_taken)
        begin
            case (state)
                cmd_pkg::st_command:
                begin
                    job.op <= cmd_op;
                    job.beats <= cmd_beats;
                end
                cmd_pkg::st_store_addr,
                cmd_pkg::st_memset_addr: aw_base <= s_cmd_beat.data[bus_pkg::addr_width-1:0];
                cmd_pkg::st_memset_val: job.fill <= s_cmd_beat.data;
                default: job.op <= job.op;
            endcase
        end
    end

endmodule

/* hw/write_addr_gen.sv */
`timescale 1ns/1ps
/*
 Write address channel for STORE and MEMSET jobs.
 One single-beat write per word, addresses step by 4 bytes.
 aw_start is ignored unless the previous job has fully issued.
 Addresses wrap silently at the top of the 16-bit space.
*/
module write_addr_gen
(
    input  logic                 aclk,
    input  logic                 resetn,
    input  bus_pkg::addr_t       aw_base,
    input  bus_pkg::beat_count_t aw_beats,
    input  logic                 aw_start,
    output logic                 aw_idle,
    output bus_pkg::addr_t       m_mem_awaddr,
    input  logic                 m_mem_awready,
    output logic                 m_mem_awvalid
);
    bus_pkg::addr_t       addr_q;
    bus_pkg::beat_count_t remaining;
    logic                 aw_fire;

    // Valid as long as addresses are left, so it rises after aw_start
    assign aw_idle = remaining == '0;
    assign m_mem_awvalid = !aw_idle;
    assign m_mem_awaddr = addr_q;
    assign aw_fire = m_mem_awvalid && m_mem_awready;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            remaining <= '0;
        end
        else if (aw_start && aw_idle)
        begin
            remaining <= aw_beats;
        end
        else if (aw_fire)
        begin
            remaining <= remaining - bus_pkg::beat_count_t'(1);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (aw_start && aw_idle)
        begin
            addr_q <= aw_base;
        end
        else if (aw_fire)
        begin
            addr_q <= addr_q + bus_pkg::addr_t'(bus_pkg::bytes_per_beat);
        end
    end

endmodule

/* hw/beat_mover.sv */
`timescale 1ns/1ps
/*
 Moves the payload words of one job from source to destination.
 Source is the command input (STREAM, STORE) or the fill value (MEMSET).
 Destination is the command output (STREAM) or write data (STORE, MEMSET).
 One register stage plus a one-entry skid buffer, full rate when unstalled.
 mover_done pulses one cycle after the final word transfers.
*/
module beat_mover
(
    input  logic              aclk,
    input  logic              resetn,
    input  bus_pkg::job_t     job,
    input  logic              mover_start,
    output logic              mover_done,
    input  logic              s_cmd_valid,
    input  bus_pkg::beat_t    s_cmd_beat,
    output logic              src_ready,
    output logic              m_cmd_valid,
    input  logic              m_cmd_ready,
    output bus_pkg::beat_t    m_cmd_beat,
    output logic              m_mem_wvalid,
    input  logic              m_mem_wready,
    output bus_pkg::data_t    m_mem_wdata
);
    cmd_pkg::opcode_t     op_q;
    bus_pkg::data_t       fill_q;
    bus_pkg::beat_count_t count;
    bus_pkg::beat_t       src_beat;
    bus_pkg::beat_t       out_q;
    bus_pkg::beat_t       skid_q;
    logic                 out_valid;
    logic                 skid_valid;
    logic                 from_cmd;
    logic                 to_cmd;
    logic                 src_valid;
    logic                 dst_ready;
    logic                 take;
    logic                 accept;
    logic                 load_out;

    // Source and destination selection
    assign from_cmd = (op_q == cmd_pkg::op_stream) || (op_q == cmd_pkg::op_store);
    assign to_cmd = op_q == cmd_pkg::op_stream;
    assign src_valid = from_cmd ? s_cmd_valid : 1'b1;
    assign src_beat.data = from_cmd ? s_cmd_beat.data : fill_q;
    assign src_beat.last = count == bus_pkg::beat_count_t'(1);
    assign dst_ready = to_cmd ? m_cmd_ready : m_mem_wready;

    // Stop taking words once the skid entry is in use
    assign take = !skid_valid && (count != '0);
    assign src_ready = take && from_cmd;
    assign accept = take && src_valid;
    assign load_out = !out_valid || dst_ready;

    assign m_cmd_valid = out_valid && to_cmd;
    assign m_cmd_beat = out_q;
    assign m_mem_wvalid = out_valid && !to_cmd;
    assign m_mem_wdata = out_q.data;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            op_q <= cmd_pkg::op_nop;
            count <= '0;
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
            mover_done <= 1'b0;
        end
        else
        begin
            mover_done <= out_valid && dst_ready && out_q.last;
            if (mover_start)
            begin
                op_q <= job.op;
                count <= job.beats;
            end
            else if (accept)
            begin
                count <= count - bus_pkg::beat_count_t'(1);
            end
            if (load_out)
            begin
                // Skid entry drains first, no new word is taken meanwhile
                out_valid <= skid_valid || accept;
                skid_valid <= 1'b0;
            end
            else if (accept)
            begin
                skid_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (mover_start)
        begin
            fill_q <= job.fill;
        end
        if (load_out)
        begin
            out_q <= skid_valid ? skid_q : src_beat;
        end
        else if (accept)
        begin
            skid_q <= src_beat;
        end
    end

endmodule

/* hw/pre_command_parser.sv */
`timescale 1ns/1ps
/*
 Command front end: command stream in, command stream and memory writes out.
 Every memory write is a single beat, there is no read side and no
 write response. Commands are handled one at a time.
*/
module pre_command_parser
(
    input  logic           aclk,
    input  logic           resetn,

    input  logic           s_cmd_valid,
    output logic           s_cmd_ready,
    input  bus_pkg::beat_t s_cmd_beat,

    output logic           m_cmd_valid,
    input  logic           m_cmd_ready,
    output bus_pkg::beat_t m_cmd_beat,

    output bus_pkg::addr_t m_mem_awaddr,
    output logic           m_mem_awvalid,
    input  logic           m_mem_awready,
    output bus_pkg::data_t m_mem_wdata,
    output logic           m_mem_wvalid,
    input  logic           m_mem_wready
);
    bus_pkg::job_t        job;
    bus_pkg::addr_t       aw_base;
    bus_pkg::beat_count_t aw_beats;
    logic                 parse_ready;
    logic                 src_ready;
    logic                 mover_start;
    logic                 mover_done;
    logic                 aw_start;
    logic                 aw_idle;

    // Decoder and mover never consume words in the same cycle
    assign s_cmd_ready = parse_ready || src_ready;

    cmd_decoder cmd_decoder_inst
    (
        .aclk        (aclk),
        .resetn      (resetn),
        .s_cmd_valid (s_cmd_valid),
        .s_cmd_beat  (s_cmd_beat),
        .parse_ready (parse_ready),
        .job         (job),
        .mover_start (mover_start),
        .mover_done  (mover_done),
        .aw_base     (aw_base),
        .aw_beats    (aw_beats),
        .aw_start    (aw_start),
        .aw_idle     (aw_idle)
    );

    write_addr_gen write_addr_gen_inst
    (
        .aclk          (aclk),
        .resetn        (resetn),
        .aw_base       (aw_base),
        .aw_beats      (aw_beats),
        .aw_start      (aw_start),
        .aw_idle       (aw_idle),
        .m_mem_awaddr  (m_mem_awaddr),
        .m_mem_awready (m_mem_awready),
        .m_mem_awvalid (m_mem_awvalid)
    );

    beat_mover beat_mover_inst
    (
        .aclk         (aclk),
        .resetn       (resetn),
        .job          (job),
        .mover_start  (mover_start),
        .mover_done   (mover_done),
        .s_cmd_valid  (s_cmd_valid),
        .s_cmd_beat   (s_cmd_beat),
        .src_ready    (src_ready),
        .m_cmd_valid  (m_cmd_valid),
        .m_cmd_ready  (m_cmd_ready),
        .m_cmd_beat   (m_cmd_beat),
        .m_mem_wvalid (m_mem_wvalid),
        .m_mem_wready (m_mem_wready),
        .m_mem_wdata  (m_mem_wdata)
    );

endmodule

/* testbench/pre_command_parser_properties.sv */
`timescale 1ns/1ps
/*
 Handshake rules on the top-level channels. Payload must hold while a
 transfer is pending, and no valid may rise in the first cycle out of reset.
*/
module pre_command_parser_properties
(
    input logic           aclk,
    input logic           resetn,
    input logic           s_cmd_valid,
    input logic           s_cmd_ready,
    input bus_pkg::beat_t s_cmd_beat,
    input logic           m_cmd_valid,
    input logic           m_cmd_ready,
    input bus_pkg::beat_t m_cmd_beat,
    input bus_pkg::addr_t m_mem_awaddr,
    input logic           m_mem_awvalid,
    input logic           m_mem_awready,
    input bus_pkg::data_t m_mem_wdata,
    input logic           m_mem_wvalid,
    input logic           m_mem_wready
);
    s_cmd_hold: assert property (@(posedge aclk) disable iff (!resetn)
        s_cmd_valid && !s_cmd_ready |=> s_cmd_valid && $stable(s_cmd_beat))
        else $error("command input dropped or changed before transfer");

    m_cmd_hold: assert property (@(posedge aclk) disable iff (!resetn)
        m_cmd_valid && !m_cmd_ready |=> m_cmd_valid && $stable(m_cmd_beat))
        else $error("command output dropped or changed before transfer");

    aw_hold: assert property (@(posedge aclk) disable iff (!resetn)
        m_mem_awvalid && !m_mem_awready |=> m_mem_awvalid && $stable(m_mem_awaddr))
        else $error("write address dropped or changed before transfer");

    w_hold: assert property (@(posedge aclk) disable iff (!resetn)
        m_mem_wvalid && !m_mem_wready |=> m_mem_wvalid && $stable(m_mem_wdata))
        else $error("write data dropped or changed before transfer");

    quiet_after_reset: assert property (@(posedge aclk)
        $rose(resetn) |-> !m_cmd_valid && !m_mem_awvalid && !m_mem_wvalid)
        else $error("valid high in the first cycle after reset");

endmodule

bind pre_command_parser pre_command_parser_properties pre_command_parser_properties_inst
(
    .aclk          (aclk),
    .resetn        (resetn),
    .s_cmd_valid   (s_cmd_valid),
    .s_cmd_ready   (s_cmd_ready),
    .s_cmd_beat    (s_cmd_beat),
    .m_cmd_valid   (m_cmd_valid),
    .m_cmd_ready   (m_cmd_ready),
    .m_cmd_beat    (m_cmd_beat),
    .m_mem_awaddr  (m_mem_awaddr),
    .m_mem_awvalid (m_mem_awvalid),
    .m_mem_awready (m_mem_awready),
    .m_mem_wdata   (m_mem_wdata),
    .m_mem_wvalid  (m_mem_wvalid),
    .m_mem_wready  (m_mem_wready)
);

/* testbench/tb_pre_command_parser.sv */
`timescale 1ns/1ps
/*
 Testbench for the command front end. Applies a table of commands with random
 input gaps and random back-pressure on every output channel.
 Byte counts in the table are always non-zero multiples of 4.
*/
module tb_pre_command_parser;

    localparam int wait_limit = 2000;
    localparam int settle_cycles = 8;

    typedef struct
    {
        string            name;
        cmd_pkg::opcode_t op;
        int               words;
        bus_pkg::addr_t   addr;
        bus_pkg::data_t   fill;
        bus_pkg::data_t   base;
    } row_t;

    logic           aclk;
    logic           resetn;
    logic           s_cmd_valid;
    logic           s_cmd_ready;
    bus_pkg::beat_t s_cmd_beat;
    logic           m_cmd_valid;
    logic           m_cmd_ready;
    bus_pkg::beat_t m_cmd_beat;
    bus_pkg::addr_t m_mem_awaddr;
    logic           m_mem_awvalid;
    logic           m_mem_awready;
    bus_pkg::data_t m_mem_wdata;
    logic           m_mem_wvalid;
    logic           m_mem_wready;

    row_t           rows[6];
    bus_pkg::beat_t out_q[$];
    bus_pkg::addr_t aw_q[$];
    bus_pkg::data_t w_q[$];
    int             errors;
    int             failed_tests;
    int             test_count;
    bit             timed_out;

    pre_command_parser pre_command_parser_inst
    (
        .aclk          (aclk),
        .resetn        (resetn),
        .s_cmd_valid   (s_cmd_valid),
        .s_cmd_ready   (s_cmd_ready),
        .s_cmd_beat    (s_cmd_beat),
        .m_cmd_valid   (m_cmd_valid),
        .m_cmd_ready   (m_cmd_ready),
        .m_cmd_beat    (m_cmd_beat),
        .m_mem_awaddr  (m_mem_awaddr),
        .m_mem_awvalid (m_mem_awvalid),
        .m_mem_awready (m_mem_awready),
        .m_mem_wdata   (m_mem_wdata),
        .m_mem_wvalid  (m_mem_wvalid),
        .m_mem_wready  (m_mem_wready)
    );

    initial
    begin
        aclk = 1'b0;
        forever #10 aclk = ~aclk;
    end

    // Sink and memory model stall at random
    always @(posedge aclk)
    begin
        m_cmd_ready <= ($urandom % 4) != 0;
        m_mem_awready <= ($urandom % 3) != 0;
        m_mem_wready <= ($urandom % 4) != 0;
    end

    // Addresses and data are queued apart and paired in order later
    always @(posedge aclk)
    begin
        if (resetn)
        begin
            if (m_cmd_valid && m_cmd_ready)
                out_q.push_back(m_cmd_beat);
            if (m_mem_awvalid && m_mem_awready)
                aw_q.push_back(m_mem_awaddr);
            if (m_mem_wvalid && m_mem_wready)
                w_q.push_back(m_mem_wdata);
        end
    end

    task automatic note_timeout(input string what);
        timed_out = 1'b1;
        $display("Timeout: %s did not happen in time", what);
    endtask

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            errors++;
            $display("** Error %s: expected %0d transfers, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_beat(input string name, input bus_pkg::beat_t expected,
                              input bus_pkg::beat_t actual);
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_write(input string name, input bus_pkg::addr_t exp_addr,
                               input bus_pkg::data_t exp_data, input bus_pkg::addr_t act_addr,
                               input bus_pkg::data_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data)
        begin
            errors++;
            $display("** Error %s: expected addr %h data %h, actual addr %h data %h",
                     name, exp_addr, exp_data, act_addr, act_data);
        end
    endtask

    // Offers one word, sometimes after a gap, and returns once it transferred
    task automatic send_word(input bus_pkg::data_t data, input logic last);
        bus_pkg::beat_t beat;
        int             cycles;
        int             gap;
        beat.data = data;
        beat.last = last;
        gap = $urandom % 3;
        if (gap != 0)
        begin
            s_cmd_valid <= 1'b0;
            repeat (gap) @(posedge aclk);
        end
        s_cmd_valid <= 1'b1;
        s_cmd_beat <= beat;
        cycles = 0;
        do
        begin
            @(posedge aclk);
            cycles++;
            if (cycles > wait_limit)
                note_timeout("command word transfer");
        end
        while (!(s_cmd_valid && s_cmd_ready) && !timed_out);
    endtask

    function automatic bit results_in(input int out_words, input int mem_words);
        return out_q.size() >= out_words && aw_q.size() >= mem_words && w_q.size() >= mem_words;
    endfunction

    task automatic run_row(input row_t r);
        bus_pkg::data_t cmd;
        bus_pkg::beat_t exp_beat;
        int             out_words;
        int             mem_words;
        int             cycles;
        bit             has_addr;
        bit             has_payload;
        has_addr = r.op == cmd_pkg::op_store || r.op == cmd_pkg::op_memset;
        has_payload = r.op == cmd_pkg::op_store || r.op == cmd_pkg::op_stream;
        out_words = (r.op == cmd_pkg::op_stream) ? r.words : 0;
        mem_words = has_addr ? r.words : 0;
        out_q.delete();
        aw_q.delete();
        w_q.delete();
        cmd = {r.op, 28'(r.words * 4)};
        send_word(cmd, 1'b0);
        if (has_addr && !timed_out)
            send_word(bus_pkg::data_t'(r.addr), 1'b0);
        if (r.op == cmd_pkg::op_memset && !timed_out)
            send_word(r.fill, 1'b0);
        for (int k = 0; k < r.words && has_payload && !timed_out; k++)
            send_word(r.base + bus_pkg::data_t'(k), k == r.words - 1);
        s_cmd_valid <= 1'b0;
        cycles = 0;
        while (!timed_out && !results_in(out_words, mem_words))
        begin
            @(posedge aclk);
            cycles++;
            if (cycles > wait_limit)
                note_timeout({r.name, " results"});
        end
        // Extra cycles expose any surplus transfer
        repeat (settle_cycles) @(posedge aclk);
        check_count({r.name, " output words"}, out_words, out_q.size());
        check_count({r.name, " write addresses"}, mem_words, aw_q.size());
        check_count({r.name, " write data"}, mem_words, w_q.size());
        for (int k = 0; k < out_words && k < out_q.size(); k++)
        begin
            exp_beat.data = r.base + bus_pkg::data_t'(k);
            exp_beat.last = k == r.words - 1;
            check_beat(r.name, exp_beat, out_q[k]);
        end
        for (int k = 0; k < mem_words && k < aw_q.size() && k < w_q.size(); k++)
            check_write(r.name, r.addr + bus_pkg::addr_t'(4 * k),
                        (r.op == cmd_pkg::op_memset) ? r.fill : r.base + bus_pkg::data_t'(k),
                        aw_q[k], w_q[k]);
    endtask

    initial
    begin
        int errors_before;
        void'($urandom(32'h2662));
        rows[0] = '{"stream_4", cmd_pkg::op_stream, 4, 16'h0000, 32'h0, 32'h1000_0000};
        rows[1] = '{"store_5", cmd_pkg::op_store, 5, 16'h0100, 32'h0, 32'h2000_0000};
        rows[2] = '{"memset_6", cmd_pkg::op_memset, 6, 16'h0200, 32'hcafe_f00d, 32'h0};
        rows[3] = '{"nop", cmd_pkg::op_nop, 3, 16'h0000, 32'h0, 32'h0};
        rows[4] = '{"stream_after_nop", cmd_pkg::op_stream, 3, 16'h0000, 32'h0, 32'h3000_0000};
        rows[5] = '{"store_1", cmd_pkg::op_store, 1, 16'hfffc, 32'h0, 32'h4000_0000};
        errors = 0;
        failed_tests = 0;
        test_count = 0;
        timed_out = 1'b0;
        resetn = 1'b0;
        s_cmd_valid = 1'b0;
        s_cmd_beat = '0;
        m_cmd_ready = 1'b0;
        m_mem_awready = 1'b0;
        m_mem_wready = 1'b0;
        repeat (3) @(posedge aclk);
        resetn <= 1'b1;
        @(posedge aclk);
        check_level("reset s_cmd_ready", 1'b0, s_cmd_ready);
        check_level("reset m_cmd_valid", 1'b0, m_cmd_valid);
        check_level("reset m_mem_awvalid", 1'b0, m_mem_awvalid);
        check_level("reset m_mem_wvalid", 1'b0, m_mem_wvalid);
        test_count++;
        if (errors != 0)
            failed_tests++;
        $display("%s reset", (errors != 0) ? "FAIL" : "PASS");
        foreach (rows[i])
        begin
            if (!timed_out)
            begin
                errors_before = errors;
                run_row(rows[i]);
                test_count++;
                if (errors != errors_before || timed_out)
                begin
                    failed_tests++;
                    $display("FAIL %s", rows[i].name);
                end
                else
                    $display("PASS %s", rows[i].name);
            end
        end
        $display("Tests run %0d, failed %0d, check errors %0d", test_count, failed_tests, errors);
        if (errors == 0 && failed_tests == 0 && !timed_out)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

/* all.f */
hw/cmd_pkg.sv
hw/bus_pkg.sv
hw/cmd_decoder.sv
hw/write_addr_gen.sv
hw/beat_mover.sv
hw/pre_command_parser.sv
testbench/pre_command_parser_properties.sv
testbench/tb_pre_command_parser.sv

/* Makefile */
# Verilator build and run for the command front end

VERILATOR ?= verilator
TOP       ?= tb_pre_command_parser
DUT_TOP   ?= pre_command_parser
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, not the exit status of the simulator
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
